// ==== source/vm16_consts.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and depths shared by the 16-bit core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VM16_CONSTS_SVH
`define VM16_CONSTS_SVH

// Data, address and instruction word
`define VM16_DATA_W      16

// Instruction memory
`define VM16_IMEM_DEPTH  64
`define VM16_IMEM_AW     6

// Register file
`define VM16_NUM_REGS    8
`define VM16_REG_SEL_W   3

`endif

// ==== source/vm16_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core types: data word, opcodes, ALU ops and the decoded instruction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vm16_consts.svh"

package vm16_pkg;

    typedef logic [`VM16_DATA_W-1:0]    word_t;
    typedef logic [`VM16_REG_SEL_W-1:0] reg_sel_t;

    // Unlisted opcode values decode as NOP
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_LW    = 5'd1,
        OP_SW    = 5'd2,
        OP_MOV   = 5'd3,
        OP_MOVI  = 5'd4,
        OP_BR    = 5'd5,
        OP_BIT   = 5'd6,
        OP_ARITH = 5'd7,
        OP_HALT  = 5'd31
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_OR,
        ALU_XOR, ALU_AND, ALU_NOT, ALU_SHL, ALU_SHR
    } alu_op_t;

    typedef struct packed {
        reg_sel_t   rd;
        reg_sel_t   ra;
        logic [3:0] imm4;
        logic [7:0] imm8;
        logic [4:0] simm5;
        alu_op_t    alu_op;
        logic       has_imm4;
        logic       has_imm8;
        logic       has_we;
        logic       has_br;
        logic       has_mem;
        logic       has_mem_we;
        logic       halt;
    } decoded_t;

endpackage

// ==== source/vm16_mem_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store request channel between sequencer and APB master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface vm16_mem_if import vm16_pkg::*; ();

    // req pulses once, addr/wdata/write held until done
    logic  req;
    logic  write;
    word_t addr;
    word_t wdata;
    // done pulses once, rdata valid from then on
    logic  done;
    word_t rdata;

    modport requester (output req, write, addr, wdata, input done, rdata);
    modport completer (input req, write, addr, wdata, output done, rdata);

endinterface

// ==== source/vm16_instr_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory with synchronous read and a program load port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vm16_consts.svh"

module vm16_instr_mem import vm16_pkg::*; (
    input  logic                     clk,
    input  logic [`VM16_IMEM_AW-1:0] addr,
    input  logic                     load_we,
    input  logic [`VM16_IMEM_AW-1:0] load_addr,
    input  word_t                    load_data,
    output word_t                    instr
);

    word_t mem [`VM16_IMEM_DEPTH];

    // Load port only used while the core sits in reset
    always_ff @(posedge clk) begin
        if (load_we)
            mem[load_addr] <= load_data;
        instr <= mem[addr];
    end

endmodule

// ==== source/vm16_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder: field slicing, ALU op and control flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vm16_decoder import vm16_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    opcode_t opcode;

    assign opcode = opcode_t'(instr[15:11]);

    always_comb begin
        dec        = '0;
        dec.rd     = instr[10:8];
        dec.ra     = instr[7:5];
        dec.imm4   = instr[3:0];
        dec.imm8   = instr[7:0];
        dec.simm5  = instr[4:0];
        dec.alu_op = ALU_NOP;

        case (opcode)
            OP_LW: begin
                dec.has_mem = 1'b1;
                dec.has_we  = 1'b1;
            end
            OP_SW: begin
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                dec.alu_op = ALU_PASS_B;
                dec.has_we = 1'b1;
            end
            OP_MOVI: begin
                dec.alu_op   = ALU_PASS_B;
                dec.has_imm8 = 1'b1;
                dec.has_we   = 1'b1;
            end
            OP_BR:   dec.has_br = 1'b1;
            OP_BIT: begin
                dec.has_we = 1'b1;
                case (instr[4:0])
                    5'd0:    dec.alu_op = ALU_OR;
                    5'd1:    dec.alu_op = ALU_XOR;
                    5'd2:    dec.alu_op = ALU_AND;
                    5'd3:    dec.alu_op = ALU_NOT;
                    5'd4:    dec.alu_op = ALU_SHL;
                    5'd5:    dec.alu_op = ALU_SHR;
                    // Unknown bit function leaves rd alone
                    default: dec.has_we = 1'b0;
                endcase
            end
            OP_ARITH: begin
                dec.has_we = 1'b1;
                if (instr[4]) begin
                    case (instr[3:0])
                        4'd0:    dec.alu_op = ALU_ADD;
                        4'd1:    dec.alu_op = ALU_SUB;
                        default: dec.alu_op = ALU_NOP;
                    endcase
                end else begin
                    // Add-immediate, operand b becomes ra + imm4
                    dec.alu_op   = ALU_ADD;
                    dec.has_imm4 = 1'b1;
                end
            end
            OP_HALT: dec.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== source/vm16_regfile.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight-entry register file, one async read and one write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vm16_consts.svh"

module vm16_regfile import vm16_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_sel_t rs,
    output word_t    rd_data,
    input  logic     we,
    input  reg_sel_t ws,
    input  word_t    wd
);

    word_t regs [`VM16_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VM16_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[ws] <= wd;
        end
    end

    assign rd_data = regs[rs];

endmodule

// ==== source/vm16_alu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vm16_alu import vm16_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   c
);

    always_comb begin
        case (op)
            ALU_PASS_B: c = b;
            ALU_ADD:    c = a + b;
            ALU_SUB:    c = a - b;
            ALU_OR:     c = a | b;
            ALU_XOR:    c = a ^ b;
            ALU_AND:    c = a & b;
            // NOT works on the secondary operand only
            ALU_NOT:    c = ~b;
            // Shift amount is b mod 16
            ALU_SHL:    c = a << b[3:0];
            ALU_SHR:    c = a >> b[3:0];
            default:    c = '0;
        endcase
    end

endmodule

// ==== source/vm16_apb_master.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB master FSM serving the core's load/store requests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vm16_apb_master import vm16_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    vm16_mem_if.completer       mem,
    output word_t               paddr,
    output logic                pwrite,
    output logic                psel,
    output logic                penable,
    output word_t               pwdata,
    input  word_t               prdata,
    input  logic                pready
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

    apb_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            psel     <= 1'b0;
            penable  <= 1'b0;
            pwrite   <= 1'b0;
            paddr    <= '0;
            pwdata   <= '0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            case (state)
                IDLE: if (mem.req) begin
                    paddr  <= mem.addr;
                    pwdata <= mem.wdata;
                    pwrite <= mem.write;
                    psel   <= 1'b1;
                    state  <= SETUP;
                end
                SETUP: begin
                    penable <= 1'b1;
                    state   <= ACCESS;
                end
                // Wait states: hold here until the slave is ready
                ACCESS: if (pready) begin
                    psel     <= 1'b0;
                    penable  <= 1'b0;
                    mem.done <= 1'b1;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ACCESS && pready)
            mem.rdata <= prdata;
    end

    a_paddr_stable: assert property (@(posedge clk) disable iff (reset)
        psel && !(penable && pready) |=> $stable(paddr))
        else $error("paddr changed during an APB transfer");

    a_penable_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel)
        else $error("penable high without psel");

endmodule

// ==== source/vm16_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top: multicycle sequencer, PC and submodule instances
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vm16_consts.svh"

module vm16_core import vm16_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     prog_we,
    input  logic [`VM16_IMEM_AW-1:0] prog_addr,
    input  word_t                    prog_data,
    output word_t                    paddr,
    output logic                     pwrite,
    output logic                     psel,
    output logic                     penable,
    output word_t                    pwdata,
    input  word_t                    prdata,
    input  logic                     pready,
    output logic                     halted
);

    typedef enum logic [2:0] {ST_IF, ST_R1, ST_R2, ST_ME, ST_WB} seq_state_t;

    seq_state_t               state;
    logic [`VM16_IMEM_AW-1:0] pc;
    word_t                    imem_out;
    word_t                    instr_q;
    decoded_t                 dec;
    reg_sel_t                 reg_rs;
    word_t                    reg_rd_data;
    word_t                    rdd;
    word_t                    rda;
    word_t                    alu_c;

    vm16_mem_if mem_bus ();

    // Port reads rd in R1 and ra in R2
    assign reg_rs = (state == ST_R2) ? dec.ra : dec.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IF;
            pc          <= '0;
            halted      <= 1'b0;
            mem_bus.req <= 1'b0;
        end else if (!halted) begin
            mem_bus.req <= 1'b0;
            case (state)
                ST_IF: state <= ST_R1;
                ST_R1: state <= ST_R2;
                ST_R2: begin
                    if (dec.halt) begin
                        halted <= 1'b1;
                    end else begin
                        if (dec.has_br)
                            pc <= rdd[`VM16_IMEM_AW-1:0];
                        else
                            pc <= pc + 1'b1;
                        if (dec.has_mem) begin
                            mem_bus.req <= 1'b1;
                            state       <= ST_ME;
                        end else begin
                            state <= ST_WB;
                        end
                    end
                end
                ST_ME: if (mem_bus.done) state <= ST_WB;
                ST_WB: state <= ST_IF;
                default: state <= ST_IF;
            endcase
        end
    end

    // Instruction latch and operand registers
    always_ff @(posedge clk) begin
        if (state == ST_IF)
            instr_q <= imem_out;
        if (state == ST_R1)
            rdd <= reg_rd_data;
        if (state == ST_R2) begin
            if (dec.has_imm8)
                rda <= word_t'(dec.imm8);
            else if (dec.has_imm4)
                rda <= reg_rd_data + word_t'(dec.imm4);
            else
                rda <= reg_rd_data;
        end
    end

    // Effective address is ra + sign-extended simm5
    assign mem_bus.addr  = rda + {{(`VM16_DATA_W-5){dec.simm5[4]}}, dec.simm5};
    assign mem_bus.wdata = rdd;
    assign mem_bus.write = dec.has_mem_we;

    vm16_instr_mem u_imem (
        .clk       (clk),
        .addr      (pc),
        .load_we   (prog_we),
        .load_addr (prog_addr),
        .load_data (prog_data),
        .instr     (imem_out)
    );

    vm16_decoder u_dec (
        .instr (instr_q),
        .dec   (dec)
    );

    vm16_regfile u_regs (
        .clk     (clk),
        .reset   (reset),
        .rs      (reg_rs),
        .rd_data (reg_rd_data),
        .we      (dec.has_we && state == ST_WB),
        .ws      (dec.rd),
        .wd      (dec.has_mem ? mem_bus.rdata : alu_c)
    );

    vm16_alu u_alu (
        .op (dec.alu_op),
        .a  (rdd),
        .b  (rda),
        .c  (alu_c)
    );

    vm16_apb_master u_apb (
        .clk     (clk),
        .reset   (reset),
        .mem     (mem_bus),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    a_prog_in_reset: assert property (@(posedge clk) prog_we |-> reset)
        else $error("program load while core is running");

    // A halted core never opens a new APB setup phase
    a_no_apb_after_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !(psel && !penable))
        else $error("APB transfer started after halt");

endmodule

// ==== verif/vm16_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the core, with an APB slave model and
// a per-cycle APB protocol monitor
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "vm16_consts.svh"

module vm16_tb import vm16_pkg::*; ();

    // 88 program words over six tests at no more than 11 cycles each
    // plus loading, reset and the 50-cycle halt window is about 1150
    localparam int TIMEOUT_CYCLES = 2000;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     prog_we;
    logic [`VM16_IMEM_AW-1:0] prog_addr;
    word_t                    prog_data;
    word_t                    paddr;
    logic                     pwrite;
    logic                     psel;
    logic                     penable;
    word_t                    pwdata;
    word_t                    prdata;
    logic                     pready;
    logic                     halted;

    // Program image, slave memory and write bookkeeping
    word_t prog [`VM16_IMEM_DEPTH];
    int    prog_len;
    word_t slave_mem [256];
    word_t log_addr [$];
    word_t log_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    // Monitor state from the previous cycle and the open transfer
    logic  prev_psel;
    logic  prev_penable;
    logic  prev_pready;
    word_t held_addr;
    word_t held_wdata;
    logic  held_write;
    int    waits_left;
    int    transfer_count;

    int seed;
    int value_errors;
    int protocol_errors;
    int cycle_count;

    always #20 clk = ~clk;

    vm16_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .psel      (psel),
        .penable   (penable),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .halted    (halted)
    );

    function automatic word_t encode(opcode_t op, int rd, int ra, logic [4:0] fn);
        return {op, rd[2:0], ra[2:0], fn};
    endfunction

    function automatic word_t encode_movi(int rd, logic [7:0] imm);
        return {OP_MOVI, rd[2:0], imm};
    endfunction

    task automatic protocol_error(string what);
        $display("APB protocol error at %0t ns: %s", $time, what);
        protocol_errors++;
    endtask

    // Look at the APB outputs after each edge, then answer as the slave
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (penable && !psel)
            protocol_error("penable is high while psel is low");
        if (psel && !penable) begin
            if (prev_psel)
                protocol_error("setup phase did not follow an idle cycle");
            held_addr  = paddr;
            held_wdata = pwdata;
            held_write = pwrite;
            transfer_count++;
            waits_left = $random(seed) & 3;
            pready     = 1'b0;
        end else if (psel && penable) begin
            if (!prev_psel || (prev_penable && prev_pready))
                protocol_error("access phase without a setup phase before it");
            if (paddr !== held_addr || pwrite !== held_write || pwdata !== held_wdata)
                protocol_error("address, data or direction changed during the transfer");
            if (waits_left == 0) begin
                pready = 1'b1;
                if (pwrite) begin
                    slave_mem[paddr[7:0]] = pwdata;
                    log_addr.push_back(paddr);
                    log_data.push_back(pwdata);
                end else begin
                    prdata = slave_mem[paddr[7:0]];
                end
            end else begin
                waits_left--;
                pready = 1'b0;
            end
        end else begin
            pready = 1'b0;
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_pready  = pready;
    endtask

    task automatic start_test();
        int i;
        prog_len = 0;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < 256; i++)
            slave_mem[i] = 16'h5A00 ^ 16'(i * 263);
    endtask

    task automatic emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_write(word_t a, word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    // Program goes in under reset and reset stays for 4 more cycles
    task automatic load_program();
        int i;
        reset = 1'b1;
        for (i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = i[`VM16_IMEM_AW-1:0];
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
        repeat (4) next_cycle();
    endtask

    task automatic release_and_wait();
        reset = 1'b0;
        next_cycle();
        while (!halted)
            next_cycle();
    endtask

    task automatic run_program();
        load_program();
        release_and_wait();
    endtask

    task automatic compare_writes(string name);
        int i;
        if (log_addr.size() != exp_addr.size()) begin
            $display("FAIL %0t: %s saw %0d writes, expected %0d", $time, name,
                     log_addr.size(), exp_addr.size());
            value_errors++;
        end
        for (i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            if (log_addr[i] !== exp_addr[i] || log_data[i] !== exp_data[i]) begin
                $display("FAIL %0t: %s write %0d was %h <= %h, expected %h <= %h",
                         $time, name, i, log_addr[i], log_data[i], exp_addr[i], exp_data[i]);
                value_errors++;
            end
        end
    endtask

    task automatic test_reset_and_store();
        start_test();
        emit(encode_movi(1, 8'h5A));
        emit(encode_movi(2, 8'hC3));
        emit(encode(OP_SW, 1, 0, 5'd3));
        // Offset -2 from r0 wraps to the top of the address space
        emit(encode(OP_SW, 2, 0, 5'b11110));
        emit(encode(OP_HALT, 0, 0, 5'd0));
        expect_write(16'h0003, 16'h005A);
        expect_write(16'hFFFE, 16'h00C3);
        load_program();
        if (psel !== 1'b0 || penable !== 1'b0 || pwrite !== 1'b0 || halted !== 1'b0) begin
            $display("FAIL %0t: psel/penable/pwrite/halted not low in reset", $time);
            value_errors++;
        end
        if (paddr !== '0 || pwdata !== '0) begin
            $display("FAIL %0t: paddr %h pwdata %h not zero in reset", $time, paddr, pwdata);
            value_errors++;
        end
        release_and_wait();
        compare_writes("reset_and_store");
    endtask

    // Copy r1 into r3, apply the op with src and store r3 at slot
    task automatic alu_case(opcode_t op, int src, logic [4:0] fn, int slot, word_t expected);
        emit(encode(OP_MOV, 3, 1, 5'd0));
        emit(encode(op, 3, src, fn));
        emit(encode(OP_SW, 3, 0, slot[4:0]));
        expect_write(word_t'(slot), expected);
    endtask

    task automatic test_alu_ops();
        word_t a;
        word_t b;
        word_t sh;
        start_test();
        a  = (word_t'(8'hB6) << 8) | word_t'(8'h3D);
        b  = word_t'(8'h9E);
        sh = word_t'(8'h13);
        emit(encode_movi(1, 8'hB6));
        emit(encode_movi(6, 8'd8));
        emit(encode(OP_BIT, 1, 6, 5'd4));
        emit(encode_movi(6, 8'h3D));
        emit(encode(OP_BIT, 1, 6, 5'd0));
        emit(encode_movi(2, 8'h9E));
        // Shift amount 0x13 acts as 3
        emit(encode_movi(5, 8'h13));
        alu_case(OP_ARITH, 2, 5'h10, 0, a + b);
        alu_case(OP_ARITH, 2, 5'h11, 1, a - b);
        alu_case(OP_ARITH, 2, 5'h05, 2, a + (b + 16'd5));
        alu_case(OP_BIT, 2, 5'd0, 3, a | b);
        alu_case(OP_BIT, 2, 5'd1, 4, a ^ b);
        alu_case(OP_BIT, 2, 5'd2, 5, a & b);
        alu_case(OP_BIT, 2, 5'd3, 6, ~b);
        alu_case(OP_BIT, 5, 5'd4, 7, a << sh[3:0]);
        alu_case(OP_BIT, 5, 5'd5, 8, a >> sh[3:0]);
        emit(encode(OP_HALT, 0, 0, 5'd0));
        run_program();
        compare_writes("alu_ops");
    endtask

    task automatic test_load_modify_store();
        word_t sum_a;
        word_t sum_b;
        start_test();
        slave_mem[8'h21] = 16'hFFF1;
        sum_a = slave_mem[8'h20] + slave_mem[8'h21];
        sum_b = slave_mem[8'h22] + slave_mem[8'h1F];
        emit(encode_movi(7, 8'h20));
        emit(encode(OP_LW, 1, 7, 5'd0));
        emit(encode(OP_LW, 2, 7, 5'd1));
        emit(encode(OP_ARITH, 1, 2, 5'h10));
        emit(encode(OP_SW, 1, 7, 5'd4));
        emit(encode(OP_LW, 3, 7, 5'd2));
        emit(encode(OP_LW, 4, 7, 5'b11111));
        emit(encode(OP_ARITH, 3, 4, 5'h10));
        emit(encode(OP_SW, 3, 7, 5'd5));
        emit(encode(OP_HALT, 0, 0, 5'd0));
        expect_write(16'h0024, sum_a);
        expect_write(16'h0025, sum_b);
        run_program();
        compare_writes("load_modify_store");
    endtask

    task automatic test_branch();
        start_test();
        emit(encode_movi(1, 8'd7));
        emit(encode_movi(2, 8'h11));
        // Address 2 jumps to 7
        emit(encode(OP_BR, 1, 0, 5'd0));
        emit(encode(OP_SW, 2, 0, 5'd1));
        emit(encode(OP_SW, 2, 0, 5'd2));
        emit(encode(OP_SW, 2, 0, 5'd3));
        emit(encode(OP_SW, 2, 0, 5'd4));
        emit(encode(OP_SW, 2, 0, 5'd5));
        emit(encode_movi(1, 8'd11));
        // Address 9 jumps to 11
        emit(encode(OP_BR, 1, 0, 5'd0));
        emit(encode(OP_SW, 2, 0, 5'd6));
        emit(encode(OP_SW, 2, 0, 5'd7));
        emit(encode(OP_HALT, 0, 0, 5'd0));
        expect_write(16'h0005, 16'h0011);
        expect_write(16'h0007, 16'h0011);
        run_program();
        compare_writes("branch");
    endtask

    // Back-to-back stores and loads; r1 doubles through the slave each round
    task automatic test_apb_protocol();
        word_t value;
        int    i;
        int    start_count;
        start_test();
        value = 16'h0077;
        emit(encode_movi(1, 8'h77));
        emit(encode_movi(7, 8'h80));
        for (i = 0; i < 6; i++) begin
            emit(encode(OP_SW, 1, 7, i[4:0]));
            emit(encode(OP_LW, 2, 7, i[4:0]));
            emit(encode(OP_ARITH, 1, 2, 5'h10));
            expect_write(16'h0080 + word_t'(i), value);
            value = value + value;
        end
        emit(encode(OP_HALT, 0, 0, 5'd0));
        start_count = transfer_count;
        run_program();
        if (transfer_count - start_count != 12) begin
            $display("FAIL %0t: %0d APB transfers, expected 12", $time,
                     transfer_count - start_count);
            value_errors++;
        end
        compare_writes("apb_protocol");
    endtask

    task automatic test_halt_quiet();
        int count_at_halt;
        start_test();
        emit(encode_movi(1, 8'h33));
        emit(encode(OP_SW, 1, 0, 5'd9));
        emit(encode(OP_HALT, 0, 0, 5'd0));
        emit(encode(OP_SW, 1, 0, 5'd10));
        expect_write(16'h0009, 16'h0033);
        run_program();
        count_at_halt = transfer_count;
        repeat (50) begin
            next_cycle();
            if (halted !== 1'b1) begin
                $display("FAIL %0t: halted dropped after HALT", $time);
                value_errors++;
            end
        end
        if (transfer_count != count_at_halt) begin
            $display("FAIL %0t: %0d APB transfers after HALT", $time,
                     transfer_count - count_at_halt);
            value_errors++;
        end
        compare_writes("halt_quiet");
    endtask

    initial begin
        reset           = 1'b1;
        prog_we         = 1'b0;
        prog_addr       = '0;
        prog_data       = '0;
        pready          = 1'b0;
        prdata          = '0;
        seed            = 77;
        value_errors    = 0;
        protocol_errors = 0;
        transfer_count  = 0;
        waits_left      = 0;
        prev_psel       = 1'b0;
        prev_penable    = 1'b0;
        prev_pready     = 1'b0;
        held_addr       = '0;
        held_wdata      = '0;
        held_write      = 1'b0;
        repeat (4) next_cycle();
        test_reset_and_store();
        test_alu_ops();
        test_load_modify_store();
        test_branch();
        test_apb_protocol();
        test_halt_quiet();
        $display("Closing: %0d value errors, %0d APB protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the core never finished the tests", cycle_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/vm16_pkg.sv
source/vm16_mem_if.sv
source/vm16_instr_mem.sv
source/vm16_decoder.sv
source/vm16_regfile.sv
source/vm16_alu.sv
source/vm16_apb_master.sv
source/vm16_core.sv
verif/vm16_tb.sv

// ==== Makefile ====
# Verilator build and run for the vm16 core testbench

.PHONY: all lint clean

all: obj_dir/Vvm16_tb
	./obj_dir/Vvm16_tb | tee sim.log
	grep -q "All tests passed" sim.log

obj_dir/Vvm16_tb: verilog.f $(wildcard source/*.sv source/*.svh verif/*.sv)
	verilator --binary --timing --assert --top-module vm16_tb -f verilog.f

lint:
	verilator --lint-only -Wall --timing --top-module vm16_tb -f verilog.f

clean:
	rm -rf obj_dir sim.log
